// ==== verilog/muldiv_consts.svh ====
/*
 muldiv constants
 register widths, unit latencies and the M-extension funct3 codes
 bit 2 of funct3 picks the divider
 */
`ifndef MULDIV_CONSTS_SVH
`define MULDIV_CONSTS_SVH

`define REG_DATA_WIDTH 32       // register word
`define REG_ADDR_WIDTH 5        // x0..x31

`define MUL_LATENCY    3        // multiplier partial-sum stages
`define DIV_ITERS      32       // restoring divider shift-subtract steps

`define F3_MUL         3'b000
`define F3_MULH        3'b001
`define F3_MULHSU      3'b010
`define F3_MULHU       3'b011
`define F3_DIV         3'b100
`define F3_DIVU        3'b101
`define F3_REM         3'b110
`define F3_REMU        3'b111

`endif

// ==== verilog/muldiv_op_pkg.sv ====
/*
 muldiv op types
 operation codes seen by the multiplier and the divider
 encodings follow funct3[1:0] so decode is a plain cast
 */
package muldiv_op_pkg;

    // multiplier ops
    typedef enum logic [1:0] {
        MUL    = 2'd0,  // low word, sign does not matter
        MULH   = 2'd1,  // high word, signed x signed
        MULHSU = 2'd2,  // high word, signed x unsigned
        MULHU  = 2'd3   // high word, unsigned x unsigned
    } mul_op_e;

    // divider ops
    // quotient ops first, then remainder
    typedef enum logic [1:0] {
        DIV  = 2'd0,    // signed quotient
        DIVU = 2'd1,    // unsigned quotient
        REM  = 2'd2,    // signed remainder
        REMU = 2'd3     // unsigned remainder
    } div_op_e;

endpackage

// ==== verilog/muldiv_data_pkg.sv ====
/*
 muldiv data types
 register word, register address and full product width
 */
`include "muldiv_consts.svh"

package muldiv_data_pkg;

    // one architectural register
    typedef logic [`REG_DATA_WIDTH-1:0] reg_data_t;

    // destination register index
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;

    // 32x32 product, both halves
    typedef logic [2*`REG_DATA_WIDTH-1:0] dword_t;

endpackage

// ==== verilog/muldiv_if.sv ====
/*
 muldiv_if
 issue and result bus between the control stage and one execution unit
 op type is a parameter so the same bus serves multiplier and divider
 */
`timescale 1ns/1ps

interface muldiv_if #(
    parameter type op_t = logic [1:0]
) ();

    // issue side, driven by control
    logic                       start;          // level, sampled while unit idle
    op_t                        op;
    muldiv_data_pkg::reg_data_t operand_a;      // rs1
    muldiv_data_pkg::reg_data_t operand_b;      // rs2
    muldiv_data_pkg::reg_addr_t waddr;          // rd

    // status side, driven by the unit
    logic                       busy;
    logic                       ready;          // one-cycle pulse
    muldiv_data_pkg::reg_data_t result;         // valid with ready only
    muldiv_data_pkg::reg_addr_t result_waddr;

    modport ctrl (
        output start, op, operand_a, operand_b, waddr,
        input  busy, ready, result, result_waddr
    );

    modport unit (
        input  start, op, operand_a, operand_b, waddr,
        output busy, ready, result, result_waddr
    );

endinterface

// ==== verilog/exu_muldiv_ctrl.sv ====
/*
 exu_muldiv_ctrl
 issue stage of the M-extension block
 decodes funct3, starts the multiplier or divider, holds dispatch
 while work is pending and muxes the writeback from the unit that
 finishes
 */
`timescale 1ns/1ps
`include "muldiv_consts.svh"

module exu_muldiv_ctrl (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       req_i,
    input  logic [2:0]                 funct3_i,
    input  muldiv_data_pkg::reg_data_t rs1_data_i,
    input  muldiv_data_pkg::reg_data_t rs2_data_i,
    input  muldiv_data_pkg::reg_addr_t rd_addr_i,
    input  logic                       int_assert_i,
    muldiv_if.ctrl                     mul_bus,
    muldiv_if.ctrl                     div_bus,
    output logic                       hold_o,
    output logic                       reg_we_o,
    output muldiv_data_pkg::reg_data_t reg_wdata_o,
    output muldiv_data_pkg::reg_addr_t reg_waddr_o
);

    logic                   is_div;         // divider class
    logic                   issued_q;       // result already written, req not yet dropped
    logic                   mul_req;        // live multiply request
    logic                   div_req;        // live divide request
    logic                   sel_div;        // writeback from divider
    muldiv_op_pkg::mul_op_e mul_op;
    muldiv_op_pkg::div_op_e div_op;

    assign is_div = funct3_i[2];

    // funct3 to unit op
    always_comb begin
        mul_op = muldiv_op_pkg::MUL;
        div_op = muldiv_op_pkg::DIV;
        case (funct3_i)
            `F3_MUL:    mul_op = muldiv_op_pkg::MUL;
            `F3_MULH:   mul_op = muldiv_op_pkg::MULH;
            `F3_MULHSU: mul_op = muldiv_op_pkg::MULHSU;
            `F3_MULHU:  mul_op = muldiv_op_pkg::MULHU;
            `F3_DIV:    div_op = muldiv_op_pkg::DIV;
            `F3_DIVU:   div_op = muldiv_op_pkg::DIVU;
            `F3_REM:    div_op = muldiv_op_pkg::REM;
            `F3_REMU:   div_op = muldiv_op_pkg::REMU;
            default: begin
                mul_op = muldiv_op_pkg::MUL;
                div_op = muldiv_op_pkg::DIV;
            end
        endcase
    end

    // a request counts only until its result has been written
    assign mul_req = req_i & ~is_div & ~issued_q;
    assign div_req = req_i & is_div & ~issued_q;

    // operands go to both units, only the started one latches them
    assign mul_bus.op        = mul_op;
    assign mul_bus.operand_a = rs1_data_i;
    assign mul_bus.operand_b = rs2_data_i;
    assign mul_bus.waddr     = rd_addr_i;

    assign div_bus.op        = div_op;
    assign div_bus.operand_a = rs1_data_i;      // dividend
    assign div_bus.operand_b = rs2_data_i;      // divisor
    assign div_bus.waddr     = rd_addr_i;

    // start priority
    // interrupt blocks, then a fresh request not yet ready, then a busy unit keeps it
    assign mul_bus.start = int_assert_i ? 1'b0 :
                           (mul_req && !mul_bus.ready) ? 1'b1 :
                           mul_bus.busy;

    assign div_bus.start = int_assert_i ? 1'b0 :
                           (div_req && !div_bus.ready) ? 1'b1 :
                           div_bus.busy;

    // stall dispatch until the requested class returns
    assign hold_o = (mul_req && !mul_bus.ready) ||
                    (div_req && !div_bus.ready) ||
                    mul_bus.busy || div_bus.busy;

    // writeback is always taken, so any ready pulse writes
    assign reg_we_o = mul_bus.ready | div_bus.ready;

    // both ready at once only if something odd happened, requested class wins
    assign sel_div = div_bus.ready & (~mul_bus.ready | (req_i & is_div));

    assign reg_wdata_o = sel_div ? div_bus.result :
                         mul_bus.ready ? mul_bus.result : '0;

    assign reg_waddr_o = sel_div ? div_bus.result_waddr :
                         mul_bus.ready ? mul_bus.result_waddr : '0;

    // set on writeback while req_i still high, cleared once req_i is seen low
    // req_i has to be low at one edge between two instructions
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            issued_q <= 1'b0;
        end else begin
            issued_q <= req_i & (issued_q | reg_we_o);
        end
    end

endmodule

// ==== verilog/exu_mul.sv ====
/*
 exu_mul
 multi-cycle 32x32 multiplier for MUL, MULH, MULHSU and MULHU
 two 16x32 slices and a signed correction, one registered stage each,
 then a result pulse with the low or high word
 */
`timescale 1ns/1ps
`include "muldiv_consts.svh"

module exu_mul (
    input  logic   clk,
    input  logic   rst_n_i,
    muldiv_if.unit bus
);

    localparam int W     = `REG_DATA_WIDTH;
    localparam int CNT_W = $clog2(`MUL_LATENCY + 1);

    logic                       busy_q;
    logic                       ready_q;
    logic [CNT_W-1:0]           cnt_q;          // stages left, 0 means finishing
    logic                       accept;
    logic                       sign_a;         // rs1 taken as negative
    logic                       sign_b;         // rs2 taken as negative
    logic [15:0]                slice;          // current 16 bits of rs1
    logic [W+15:0]              slice_prod;     // 16x32 partial product
    muldiv_op_pkg::mul_op_e     op_q;
    muldiv_data_pkg::reg_addr_t waddr_q;
    muldiv_data_pkg::reg_data_t a_q;
    muldiv_data_pkg::reg_data_t b_q;
    muldiv_data_pkg::reg_data_t corr_q;         // signed fixup, applied at bit 32
    muldiv_data_pkg::dword_t    acc_q;          // running product

    assign accept = bus.start & ~busy_q & ~ready_q;

    // rs1 signed for MULH/MULHSU, rs2 signed for MULH only
    assign sign_a = ((bus.op == muldiv_op_pkg::MULH) || (bus.op == muldiv_op_pkg::MULHSU)) &
                    bus.operand_a[W-1];
    assign sign_b = (bus.op == muldiv_op_pkg::MULH) & bus.operand_b[W-1];

    assign slice      = (cnt_q == CNT_W'(`MUL_LATENCY)) ? a_q[15:0] : a_q[W-1:16];
    assign slice_prod = slice * b_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q  <= 1'b0;
            ready_q <= 1'b0;
            cnt_q   <= '0;
        end else begin
            ready_q <= 1'b0;                    // pulse
            if (accept) begin
                busy_q <= 1'b1;
                cnt_q  <= CNT_W'(`MUL_LATENCY);
            end else if (busy_q) begin
                if (cnt_q != '0) begin
                    cnt_q <= cnt_q - 1'b1;
                end else begin
                    busy_q  <= 1'b0;            // last busy cycle
                    ready_q <= 1'b1;
                end
            end
        end
    end

    // (a - 2^32 sa)(b - 2^32 sb) mod 2^64 = a*b - 2^32 (sa*b + sb*a)
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q    <= bus.op;
            waddr_q <= bus.waddr;
            a_q     <= bus.operand_a;
            b_q     <= bus.operand_b;
            corr_q  <= (sign_a ? bus.operand_b : '0) + (sign_b ? bus.operand_a : '0);
        end else if (busy_q) begin
            if (cnt_q == CNT_W'(`MUL_LATENCY)) begin
                acc_q <= {16'b0, slice_prod};               // low slice
            end else if (cnt_q == CNT_W'(`MUL_LATENCY - 1)) begin
                acc_q <= acc_q + {slice_prod, 16'b0};       // high slice
            end else if (cnt_q == CNT_W'(`MUL_LATENCY - 2)) begin
                acc_q <= acc_q - {corr_q, {W{1'b0}}};       // sign fixup
            end
        end
    end

    assign bus.busy         = busy_q;
    assign bus.ready        = ready_q;
    assign bus.result       = (op_q == muldiv_op_pkg::MUL) ? acc_q[W-1:0] : acc_q[2*W-1:W];
    assign bus.result_waddr = waddr_q;

endmodule

// ==== verilog/exu_div.sv ====
/*
 exu_div
 restoring radix-2 divider for DIV, DIVU, REM and REMU
 works on magnitudes, then fixes signs; latency does not depend on
 the operands, including the divide-by-zero and overflow cases
 */
`timescale 1ns/1ps
`include "muldiv_consts.svh"

module exu_div (
    input  logic   clk,
    input  logic   rst_n_i,
    muldiv_if.unit bus
);

    localparam int W     = `REG_DATA_WIDTH;
    localparam int CNT_W = $clog2(`DIV_ITERS + 1);

    logic                       busy_q;
    logic                       ready_q;
    logic [CNT_W-1:0]           cnt_q;          // iterations left
    logic                       accept;
    logic                       is_signed;      // DIV or REM
    logic                       sign_a;
    logic                       sign_b;
    muldiv_data_pkg::reg_data_t abs_a;
    muldiv_data_pkg::reg_data_t abs_b;
    logic [W:0]                 rem_shift;      // partial remainder with next dividend bit
    logic [W:0]                 trial;          // shifted remainder minus divisor
    muldiv_data_pkg::reg_data_t quo_fix;
    muldiv_data_pkg::reg_data_t rem_fix;
    muldiv_op_pkg::div_op_e     op_q;
    muldiv_data_pkg::reg_addr_t waddr_q;
    muldiv_data_pkg::reg_data_t quo_q;          // dividend shifts out, quotient shifts in
    muldiv_data_pkg::reg_data_t rem_q;
    muldiv_data_pkg::reg_data_t dvsr_q;
    logic                       zero_q;         // divisor was zero
    logic                       quo_neg_q;
    logic                       rem_neg_q;
    muldiv_data_pkg::reg_data_t result_q;

    assign accept = bus.start & ~busy_q & ~ready_q;

    assign is_signed = (bus.op == muldiv_op_pkg::DIV) || (bus.op == muldiv_op_pkg::REM);
    assign sign_a    = is_signed & bus.operand_a[W-1];
    assign sign_b    = is_signed & bus.operand_b[W-1];
    assign abs_a     = sign_a ? -bus.operand_a : bus.operand_a;
    assign abs_b     = sign_b ? -bus.operand_b : bus.operand_b;

    assign rem_shift = {rem_q, quo_q[W-1]};
    assign trial     = rem_shift - {1'b0, dvsr_q};

    // zero divisor gives all ones; remainder already equals the dividend
    // most negative / -1 needs nothing, |a| is 2^31 and the signs cancel
    assign quo_fix = zero_q ? '1 : (quo_neg_q ? -quo_q : quo_q);
    assign rem_fix = rem_neg_q ? -rem_q : rem_q;   // takes dividend sign

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q  <= 1'b0;
            ready_q <= 1'b0;
            cnt_q   <= '0;
        end else begin
            ready_q <= 1'b0;
            if (accept) begin
                busy_q <= 1'b1;
                cnt_q  <= CNT_W'(`DIV_ITERS);
            end else if (busy_q) begin
                if (cnt_q != '0) begin
                    cnt_q <= cnt_q - 1'b1;
                end else begin
                    busy_q  <= 1'b0;            // sign fix cycle done
                    ready_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q      <= bus.op;
            waddr_q   <= bus.waddr;
            quo_q     <= abs_a;
            dvsr_q    <= abs_b;
            rem_q     <= '0;
            zero_q    <= (bus.operand_b == '0);
            quo_neg_q <= sign_a ^ sign_b;
            rem_neg_q <= sign_a;
        end else if (busy_q) begin
            if (cnt_q != '0) begin
                if (!trial[W]) begin            // fits, keep difference
                    rem_q <= trial[W-1:0];
                    quo_q <= {quo_q[W-2:0], 1'b1};
                end else begin                  // restore
                    rem_q <= rem_shift[W-1:0];
                    quo_q <= {quo_q[W-2:0], 1'b0};
                end
            end else begin
                result_q <= ((op_q == muldiv_op_pkg::DIV) || (op_q == muldiv_op_pkg::DIVU)) ?
                            quo_fix : rem_fix;
            end
        end
    end

    assign bus.busy         = busy_q;
    assign bus.ready        = ready_q;
    assign bus.result       = result_q;
    assign bus.result_waddr = waddr_q;

endmodule

// ==== verilog/exu_muldiv.sv ====
/*
 exu_muldiv
 M-extension execution block of the execute unit
 control stage plus iterative multiplier and restoring divider,
 one instruction in flight, dispatch held through hold_o
 */
`timescale 1ns/1ps
`include "muldiv_consts.svh"

module exu_muldiv (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       req_i,
    input  logic [2:0]                 funct3_i,
    input  logic [`REG_DATA_WIDTH-1:0] rs1_data_i,
    input  logic [`REG_DATA_WIDTH-1:0] rs2_data_i,
    input  logic [`REG_ADDR_WIDTH-1:0] rd_addr_i,
    input  logic                       int_assert_i,
    output logic                       hold_o,
    output logic                       reg_we_o,
    output logic [`REG_DATA_WIDTH-1:0] reg_wdata_o,
    output logic [`REG_ADDR_WIDTH-1:0] reg_waddr_o
);

    // one bus per unit, op type differs
    muldiv_if #(.op_t(muldiv_op_pkg::mul_op_e)) mul_bus ();
    muldiv_if #(.op_t(muldiv_op_pkg::div_op_e)) div_bus ();

    exu_muldiv_ctrl exu_muldiv_ctrl_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .req_i        (req_i),
        .funct3_i     (funct3_i),
        .rs1_data_i   (rs1_data_i),
        .rs2_data_i   (rs2_data_i),
        .rd_addr_i    (rd_addr_i),
        .int_assert_i (int_assert_i),
        .mul_bus      (mul_bus.ctrl),
        .div_bus      (div_bus.ctrl),
        .hold_o       (hold_o),
        .reg_we_o     (reg_we_o),
        .reg_wdata_o  (reg_wdata_o),
        .reg_waddr_o  (reg_waddr_o)
    );

    exu_mul exu_mul_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .bus     (mul_bus.unit)
    );

    exu_div exu_div_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .bus     (div_bus.unit)
    );

endmodule

// ==== tests/exu_muldiv_props.sv ====
/*
 exu_muldiv_props
 concurrent checks on the control stage and both unit buses
 ready never overlaps busy
 no idle unit starts while the interrupt is asserted
 dispatch is released only by a writeback
 */
`timescale 1ns/1ps

module exu_muldiv_props (
    input logic clk,
    input logic rst_n_i,
    input logic int_assert_i,
    input logic hold_i,         // ctrl hold_o
    input logic mul_busy_i,
    input logic mul_ready_i,
    input logic div_busy_i,
    input logic div_ready_i
);

    // result pulse only after the last busy cycle
    a_mul_ready_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(mul_ready_i && mul_busy_i))
        else $error("multiplier ready and busy high together");

    a_div_ready_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(div_ready_i && div_busy_i))
        else $error("divider ready and busy high together");

    // an interrupt cycle never turns into a new busy run
    a_int_blocks_start: assert property (@(posedge clk) disable iff (!rst_n_i)
        int_assert_i |=> (!$rose(mul_busy_i) && !$rose(div_busy_i)))
        else $error("a unit started while interrupt asserted");

    // hold drops only in a writeback cycle
    a_hold_until_wb: assert property (@(posedge clk) disable iff (!rst_n_i)
        $fell(hold_i) |-> (mul_ready_i || div_ready_i))
        else $error("hold dropped without a writeback");

endmodule

// ==== tests/tb_exu_muldiv.sv ====
/*
 tb_exu_muldiv
 testbench for the M-extension block, stands in for dispatch
 LCG operands, reference model of the RISC-V M rules,
 latency, hold and interrupt checks, writeback compare at negedge
 */
`timescale 1ns/1ps
`include "muldiv_consts.svh"

module tb_exu_muldiv;

    localparam int WAIT_LIMIT = 60;     // cycles per wait for reg_we_o

    logic        clk = 1'b0;
    logic        rst_n_i;
    logic        req_i;
    logic [2:0]  funct3_i;
    logic [31:0] rs1_data_i;
    logic [31:0] rs2_data_i;
    logic [4:0]  rd_addr_i;
    logic        int_assert_i;
    logic        hold_o;
    logic        reg_we_o;
    logic [31:0] reg_wdata_o;
    logic [4:0]  reg_waddr_o;

    logic [31:0] lcg_state = 32'h6657731a;
    logic [31:0] edge_vals [4] = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000};
    logic [31:0] exp_data_q [$];        // expected writebacks in issue order
    logic [4:0]  exp_addr_q [$];
    int          data_errs   = 0;
    int          timing_errs = 0;
    int          proto_errs  = 0;

    logic        int_q      = 1'b0;     // previous cycle of the edge checks
    logic        hold_q     = 1'b0;
    logic        mul_busy_q = 1'b0;
    logic        div_busy_q = 1'b0;

    always #50 clk = ~clk;              // 100 ns period

    exu_muldiv exu_muldiv_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .req_i        (req_i),
        .funct3_i     (funct3_i),
        .rs1_data_i   (rs1_data_i),
        .rs2_data_i   (rs2_data_i),
        .rd_addr_i    (rd_addr_i),
        .int_assert_i (int_assert_i),
        .hold_o       (hold_o),
        .reg_we_o     (reg_we_o),
        .reg_wdata_o  (reg_wdata_o),
        .reg_waddr_o  (reg_waddr_o)
    );

    bind exu_muldiv_ctrl exu_muldiv_props props_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .int_assert_i (int_assert_i),
        .hold_i       (hold_o),
        .mul_busy_i   (mul_bus.busy),
        .mul_ready_i  (mul_bus.ready),
        .div_busy_i   (div_bus.busy),
        .div_ready_i  (div_bus.ready)
    );

    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // RISC-V M result straight from the spec rules
    function automatic logic [31:0] ref_result(input logic [2:0] f3, input logic [31:0] a,
                                               input logic [31:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] ub;
        logic signed [63:0] res;
        logic [63:0]        prod;
        sa   = {{32{a[31]}}, a};
        sb   = {{32{b[31]}}, b};
        ub   = {32'b0, b};
        prod = {32'b0, a} * {32'b0, b};     // unsigned full product
        case (f3)
            `F3_MUL:    return prod[31:0];
            `F3_MULHU:  return prod[63:32];
            `F3_MULH: begin
                res = sa * sb;
                return res[63:32];
            end
            `F3_MULHSU: begin
                res = sa * ub;
                return res[63:32];
            end
            `F3_DIV: begin
                if (b == 32'h0) return 32'hffff_ffff;
                if (a == 32'h8000_0000 && b == 32'hffff_ffff) return a;  // overflow
                res = sa / sb;              // truncates toward zero
                return res[31:0];
            end
            `F3_DIVU:   return (b == 32'h0) ? 32'hffff_ffff : a / b;
            `F3_REM: begin
                if (b == 32'h0) return a;
                if (a == 32'h8000_0000 && b == 32'hffff_ffff) return 32'h0;
                res = sa % sb;              // sign of dividend
                return res[31:0];
            end
            default:    return (b == 32'h0) ? a : a % b;   // REMU
        endcase
    endfunction

    // compare every writeback against the oldest outstanding instruction
    always @(negedge clk) begin
        if (rst_n_i && reg_we_o) begin
            if (exp_data_q.size() == 0) begin
                $display("reg_we_o pulsed with no instruction outstanding");
                proto_errs++;
            end else begin
                if (reg_wdata_o !== exp_data_q[0]) begin
                    $display("[ERROR] reg_wdata_o: got %h, expected %h", reg_wdata_o,
                             exp_data_q[0]);
                    data_errs++;
                end
                if (reg_waddr_o !== exp_addr_q[0]) begin
                    $display("[ERROR] reg_waddr_o: got %h, expected %h", reg_waddr_o,
                             exp_addr_q[0]);
                    data_errs++;
                end
                void'(exp_data_q.pop_front());
                void'(exp_addr_q.pop_front());
            end
        end
    end

    // bus protocol seen from outside the units
    always @(posedge clk) begin
        if (rst_n_i) begin
            if ((exu_muldiv_i.mul_bus.ready && exu_muldiv_i.mul_bus.busy) ||
                (exu_muldiv_i.div_bus.ready && exu_muldiv_i.div_bus.busy)) begin
                $display("a unit raised ready while still busy");
                proto_errs++;
            end
            if (int_q && ((exu_muldiv_i.mul_bus.busy && !mul_busy_q) ||
                          (exu_muldiv_i.div_bus.busy && !div_busy_q))) begin
                $display("a unit started while the interrupt was asserted");
                proto_errs++;
            end
            if (hold_q && !hold_o && !reg_we_o) begin
                $display("hold_o dropped without a writeback");
                proto_errs++;
            end
        end
        int_q      = int_assert_i;
        hold_q     = hold_o;
        mul_busy_q = exu_muldiv_i.mul_bus.busy;
        div_busy_q = exu_muldiv_i.div_bus.busy;
    end

    // runs one instruction from falling edge to falling edge
    // blocked is the number of interrupt cycles before the start
    // int_at is the edge count at which the interrupt rises mid-flight
    task automatic run_instr(input logic [2:0] f3, input logic [31:0] a, input logic [31:0] b,
                             input logic [4:0] rd, input int blocked, input int int_at);
        int   edges;
        int   lat;
        logic seen;
        lat = f3[2] ? (`DIV_ITERS + 1) : (`MUL_LATENCY + 1);
        exp_data_q.push_back(ref_result(f3, a, b));
        exp_addr_q.push_back(rd);
        funct3_i   = f3;
        rs1_data_i = a;
        rs2_data_i = b;
        rd_addr_i  = rd;
        req_i      = 1'b1;
        if (blocked > 0) begin
            int_assert_i = 1'b1;
            repeat (blocked) begin
                @(negedge clk);
                if (reg_we_o) begin
                    $display("reg_we_o went high while the interrupt blocked the start");
                    proto_errs++;
                end
                if (!hold_o) begin
                    $display("hold_o low with a blocked request pending");
                    proto_errs++;
                end
            end
            int_assert_i = 1'b0;            // release so the start goes out
        end
        edges = -1;                         // the first edge is the one that issues
        seen  = 1'b0;
        while (!seen && edges < WAIT_LIMIT) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            if (reg_we_o) begin
                seen = 1'b1;
            end else if (!hold_o) begin
                $display("hold_o dropped before the result was written");
                timing_errs++;
            end
            if (edges == int_at) int_assert_i = 1'b1;   // unit already running
        end
        if (!seen) begin
            $display("timeout: reg_we_o not seen within %0d cycles", WAIT_LIMIT);
            timing_errs++;
        end else begin
            if (edges != lat) begin
                $display("[ERROR] reg_we_o latency: got %h, expected %h", edges, lat);
                timing_errs++;
            end
            if (hold_o) begin
                $display("hold_o still high in the writeback cycle");
                timing_errs++;
            end
        end
        @(negedge clk);                     // req held past the writeback edge
        req_i        = 1'b0;
        int_assert_i = 1'b0;
        @(negedge clk);                     // one edge with req low between instructions
    endtask

    task automatic run_random(input logic [2:0] f3);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sh;
        logic [31:0] rd;
        a  = lcg_next();
        b  = lcg_next();
        sh = lcg_next();
        rd = lcg_next();
        if (f3[2]) b = b >> sh[4:0];        // smaller divisors for wider quotients
        run_instr(f3, a, b, rd[4:0], 0, 0);
    endtask

    initial begin
        rst_n_i      = 1'b0;
        req_i        = 1'b0;
        funct3_i     = 3'b000;
        rs1_data_i   = 32'h0;
        rs2_data_i   = 32'h0;
        rd_addr_i    = 5'h0;
        int_assert_i = 1'b0;
        repeat (8) @(negedge clk);
        rst_n_i = 1'b1;

        // idle after reset
        repeat (5) begin
            @(negedge clk);
            if (hold_o || reg_we_o) begin
                $display("hold_o or reg_we_o high with no request after reset");
                proto_errs++;
            end
        end

        // edge operand grid over all eight ops incl. div by zero and overflow
        for (int op = 0; op < 8; op++) begin
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    run_instr(3'(op), edge_vals[i], edge_vals[j], 5'(op * 4 + j), 0, 0);
                end
            end
        end

        for (int op = 0; op < 8; op++) begin
            repeat (8) run_random(3'(op));
        end

        // interrupt held past the divide latency before release
        run_instr(`F3_MULH, lcg_next(), 32'hffff_fff3, 5'd7, 40, 0);
        run_instr(`F3_REM, 32'h8000_0000, 32'h0000_0007, 5'd9, 40, 0);

        // interrupt arriving mid-flight still lets the result land
        run_instr(`F3_DIV, 32'hfedc_ba98, 32'h0000_0013, 5'd11, 0, 5);
        run_instr(`F3_MULHSU, 32'h8765_4321, 32'hf000_000f, 5'd12, 0, 2);

        // mixed classes back to back
        repeat (24) run_random(3'(lcg_next() >> 29));

        repeat (10) @(negedge clk);
        if (exp_data_q.size() != 0) begin
            $display("%0d expected writebacks never arrived", exp_data_q.size());
            proto_errs++;
        end
        $display("errors: data %0d, timing %0d, protocol %0d", data_errs, timing_errs,
                 proto_errs);
        if (data_errs + timing_errs + proto_errs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+verilog
verilog/muldiv_op_pkg.sv
verilog/muldiv_data_pkg.sv
verilog/muldiv_if.sv
verilog/exu_muldiv_ctrl.sv
verilog/exu_mul.sv
verilog/exu_div.sv
verilog/exu_muldiv.sv
tests/exu_muldiv_props.sv
tests/tb_exu_muldiv.sv

// ==== Bender.yml ====
package:
  name: exu_muldiv

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/muldiv_op_pkg.sv
      - verilog/muldiv_data_pkg.sv
      - verilog/muldiv_if.sv
      - verilog/exu_muldiv_ctrl.sv
      - verilog/exu_mul.sv
      - verilog/exu_div.sv
      - verilog/exu_muldiv.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/exu_muldiv_props.sv
      - tests/tb_exu_muldiv.sv
